/* src.f */
src/cpu_timing_pkg.sv
src/cycle_queue.sv
src/strob_gen.sv
src/bus_track.sv
src/cycle_report.sv
src/cpu_timing_top.sv
bench/tb_clock.sv
bench/cpu_timing_tb.sv

/* bench/cpu_timing_tb.sv */
// Testbench top with stimulus, bus responder, reference model, compare tasks and report
`timescale 1ns/1ps

module cpu_timing_tb;
	import cpu_timing_pkg::*;

	localparam int queue_depth = 4;
	localparam int wait_limit = 300;

	logic        clk_sys;
	logic        rst_n;
	logic        req_valid;
	cycle_req_t  req;
	logic        cond_ok;
	logic        mode;
	logic        step;
	logic        strob_fp;
	logic        strobb_fp;
	logic        bus_grant;
	logic        bus_done;
	strob_bus_t  strobes;
	logic        rec_valid;
	cycle_rec_t  rec;
	logic [15:0] cycle_count;
	logic        overflow;

	// Reference model of the records still owed by the DUT in push order
	cycle_rec_t  exp_q[$];
	// Strobe pulses seen in the running cycle
	strob_bus_t  seen;
	strob_bus_t  prev_strobes;
	strob_bus_t  fp_exp;
	logic        got_seen;
	logic        prev_cond;
	logic        step_given;
	// Step held back past the STROB1 front cycle
	logic        step_late;
	int          done_wait;
	int          rec_seen;
	int          value_errors;
	int          other_errors;
	int          n;
	logic [7:0]  next_tag;

	tb_clock clock_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n)
	);

	cpu_timing_top #(
		.queue_depth(queue_depth)
	) dut_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req(req),
		.cond_ok(cond_ok),
		.mode(mode),
		.step(step),
		.strob_fp(strob_fp),
		.strobb_fp(strobb_fp),
		.bus_grant(bus_grant),
		.bus_done(bus_done),
		.strobes(strobes),
		.rec_valid(rec_valid),
		.rec(rec),
		.cycle_count(cycle_count),
		.overflow(overflow)
	);

	task automatic check_rec(input cycle_rec_t act, input cycle_rec_t exp);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED rec: got %h expected %h", act, exp);
		end
	endtask

	task automatic check_strobes(input string name, input strob_bus_t act, input strob_bus_t exp);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED %s: got %h expected %h", name, act, exp);
		end
	endtask

	task automatic check_count(input logic [15:0] act, input logic [15:0] exp);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED cycle_count: got %h expected %h", act, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			value_errors++;
			$display("FAILED %s: got %h expected %h", name, act, exp);
		end
	endtask

	task automatic report_other(input string msg);
		other_errors++;
		$display("%s", msg);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("errors: value %0d, other %0d", value_errors, other_errors + 1);
		$display("TEST FAILED");
		$finish;
	endtask

	function automatic cycle_class_t random_class();
		return cycle_class_t'($urandom_range(4, 0));
	endfunction

	// One push on the current falling edge with a model entry only for accepted requests
	task automatic push_req(input cycle_class_t cls, input logic mem, input logic keep);
		cycle_rec_t r;
		req_valid = 1'b1;
		req.cls = cls;
		req.mem = mem;
		req.tag = next_tag;
		r.tag = next_tag;
		r.cls = cls;
		r.had_strob2 = (cls == cls_11) || (cls == cls_12);
		// Only a step held past the STROB1 front cycle leaves the cycle waiting in STROB1
		r.stepped = mode && step_late;
		r.mem = mem;
		if (keep) begin
			exp_q.push_back(r);
		end
		next_tag++;
		@(negedge clk_sys);
		req_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int cnt;
		cnt = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > wait_limit) begin
				abort_on_timeout("outstanding records");
			end
		end
	endtask

	task automatic wait_strob1();
		int cnt;
		cnt = 0;
		while (!seen.strob1) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > wait_limit) begin
				abort_on_timeout("strob1");
			end
		end
	endtask

	// Returns in the STROB1 front cycle itself
	task automatic wait_strob1_level();
		int cnt;
		cnt = 0;
		while (!strobes.strob1) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > wait_limit) begin
				abort_on_timeout("strob1 level");
			end
		end
	endtask

	// Bus side with random grant and one delayed done per memory cycle
	initial begin
		bus_grant = 1'b0;
		bus_done = 1'b0;
		done_wait = 0;
		forever begin
			@(negedge clk_sys);
			bus_done = 1'b0;
			if ($urandom_range(2, 0) == 0) begin
				bus_grant = !bus_grant;
			end
			if (done_wait > 0) begin
				done_wait--;
				if (done_wait == 0) begin
					bus_done = 1'b1;
				end
			end
		end
	end

	// Monitor samples on the rising edge what the last cycle showed
	always @(posedge clk_sys) begin
		cycle_rec_t exp_rec;
		strob_bus_t exp_bus;
		if (rst_n) begin
			// Shape rules only hold with the front panel quiet
			if (!strob_fp && !strobb_fp) begin
				if ($countones(strobes) > 1) begin
					report_other("two strobe bits high in the same cycle");
				end
				if (strobes.got) begin
					got_seen = 1'b1;
				end
				if (strobes.strob1 && !prev_strobes.strob1) begin
					if (seen.strob1) begin
						report_other("strob1 pulsed twice in one cycle");
					end
					if (exp_q.size() == 0) begin
						report_other("strob1 with no request outstanding");
					end else if (exp_q[0].cls inside {cls_12, cls_13} && !prev_cond) begin
						report_other("strob1 started while cond_ok was low");
					end
					seen.strob1 = 1'b1;
					seen.got = got_seen;
					got_seen = 1'b0;
				end
				if (strobes.strob1b && !prev_strobes.strob1b) begin
					if (seen.strob1b) begin
						report_other("strob1b pulsed twice in one cycle");
					end
					if (mode && !step_given) begin
						report_other("strob1b appeared before a step edge");
					end
					// Memory cycle opens its transfer here and gets its done later
					if (exp_q.size() != 0 && exp_q[0].mem) begin
						done_wait = $urandom_range(4, 1);
					end
					seen.strob1b = 1'b1;
				end
				if (strobes.strob2 && !prev_strobes.strob2) begin
					if (seen.strob2) begin
						report_other("strob2 pulsed twice in one cycle");
					end
					seen.strob2 = 1'b1;
				end
				if (strobes.strob2b && !prev_strobes.strob2b) begin
					if (seen.strob2b) begin
						report_other("strob2b pulsed twice in one cycle");
					end
					seen.strob2b = 1'b1;
				end
			end
			if (rec_valid) begin
				if (exp_q.size() == 0) begin
					report_other("record with no request outstanding");
				end else begin
					exp_rec = exp_q.pop_front();
					check_rec(rec, exp_rec);
					exp_bus.got = 1'b1;
					exp_bus.strob1 = 1'b1;
					exp_bus.strob1b = 1'b1;
					exp_bus.strob2 = exp_rec.had_strob2;
					exp_bus.strob2b = exp_rec.had_strob2;
					check_strobes("strobe pulses", seen, exp_bus);
				end
				rec_seen++;
				check_count(cycle_count, 16'(rec_seen));
				seen = '0;
			end
			prev_strobes = strobes;
			prev_cond = cond_ok;
		end
	end

	initial begin
		req_valid = 1'b0;
		req = '0;
		cond_ok = 1'b1;
		mode = 1'b0;
		step = 1'b0;
		strob_fp = 1'b0;
		strobb_fp = 1'b0;
		seen = '0;
		prev_strobes = '0;
		got_seen = 1'b0;
		prev_cond = 1'b1;
		step_given = 1'b0;
		step_late = 1'b0;
		rec_seen = 0;
		value_errors = 0;
		other_errors = 0;
		next_tag = 8'h00;
		void'($urandom(32'hdf52));
		n = 0;
		while (!rst_n) begin
			@(negedge clk_sys);
			n++;
			if (n > 40) begin
				abort_on_timeout("reset release");
			end
		end
		@(negedge clk_sys);
		check_flag("overflow", overflow, 1'b0);
		check_count(cycle_count, 16'h0000);

		// Random mix of classes and memory cycles within the queue depth
		for (int i = 0; i < 60; i++) begin
			if (exp_q.size() < queue_depth && $urandom_range(1, 0) == 1) begin
				push_req(random_class(), $urandom_range(1, 0), 1'b1);
			end else begin
				@(negedge clk_sys);
			end
		end
		wait_drained();

		// Condition gating holds the request back until cond_ok rises
		for (int i = 0; i < 4; i++) begin
			cond_ok = 1'b0;
			push_req((i % 2) ? cls_13 : cls_12, $urandom_range(1, 0), 1'b1);
			repeat ($urandom_range(8, 3)) @(negedge clk_sys);
			if (seen.strob1 || exp_q.size() == 0) begin
				report_other("gated request ran while cond_ok was low");
			end
			cond_ok = 1'b1;
			wait_drained();
		end

		// Single step with the step edge in the STROB1 front cycle or some cycles later
		mode = 1'b1;
		for (int i = 0; i < 4; i++) begin
			step_given = 1'b0;
			step_late = (i % 2 == 1);
			push_req(random_class(), $urandom_range(1, 0), 1'b1);
			if (step_late) begin
				wait_strob1();
				repeat ($urandom_range(2, 0)) @(negedge clk_sys);
			end else begin
				wait_strob1_level();
			end
			step_given = 1'b1;
			step = 1'b1;
			@(negedge clk_sys);
			step = 1'b0;
			wait_drained();
		end
		mode = 1'b0;

		// Front panel strobes while idle show in the same cycle and make no record
		repeat (3) @(negedge clk_sys);
		strob_fp = 1'b1;
		@(posedge clk_sys);
		fp_exp = '0;
		fp_exp.strob1 = 1'b1;
		check_strobes("strobes", strobes, fp_exp);
		@(negedge clk_sys);
		strob_fp = 1'b0;
		strobb_fp = 1'b1;
		@(posedge clk_sys);
		fp_exp = '0;
		fp_exp.strob1b = 1'b1;
		check_strobes("strobes", strobes, fp_exp);
		@(negedge clk_sys);
		strobb_fp = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_count(cycle_count, 16'(rec_seen));

		// Overflow with the queue stalled by cond_ok so the extra pushes drop
		check_flag("overflow", overflow, 1'b0);
		cond_ok = 1'b0;
		for (int i = 0; i < queue_depth + 2; i++) begin
			push_req(cls_13, $urandom_range(1, 0), i < queue_depth);
		end
		check_flag("overflow", overflow, 1'b1);
		cond_ok = 1'b1;
		wait_drained();
		repeat (5) @(negedge clk_sys);
		check_count(cycle_count, 16'(rec_seen));

		$display("errors: value %0d, other %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
// Testbench clock generator and power-on reset source
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = !clk_sys;
	end

	// Reset held for ten cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
	end

endmodule

/* src/cpu_timing_top.sv */
// Cycle timing unit top, queue, strobe generator, bus tracker and report
`timescale 1ns/1ps

module cpu_timing_top #(
	parameter int queue_depth = 4
) (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       req_valid,
	input  cpu_timing_pkg::cycle_req_t req,
	input  logic                       cond_ok,
	input  logic                       mode,
	input  logic                       step,
	input  logic                       strob_fp,
	input  logic                       strobb_fp,
	input  logic                       bus_grant,
	input  logic                       bus_done,
	output cpu_timing_pkg::strob_bus_t strobes,
	output logic                       rec_valid,
	output cpu_timing_pkg::cycle_rec_t rec,
	output logic [15:0]                cycle_count,
	output logic                       overflow
);
	import cpu_timing_pkg::*;

	// Queue head towards the strobe generator and report
	logic         head_valid;
	cycle_req_t   head;
	// End of cycle and bus handshake
	logic         ldstate;
	logic         st1b_pulse;
	logic         if_busy;
	strob_state_t state;
	logic         stepped;

	cycle_queue #(
		.depth(queue_depth)
	) queue_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req(req),
		.pop(ldstate),
		.head_valid(head_valid),
		.head(head),
		.overflow(overflow)
	);

	strob_gen strob_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.head_valid(head_valid),
		.head(head),
		.cond_ok(cond_ok),
		.if_busy(if_busy),
		.mode(mode),
		.step(step),
		.strob_fp(strob_fp),
		.strob_fp_b(strobb_fp),
		.strobes(strobes),
		.ldstate(ldstate),
		.st1b_pulse(st1b_pulse),
		.state(state),
		.stepped(stepped)
	);

	bus_track bus_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.st1b_pulse(st1b_pulse),
		.mem(head.mem),
		.bus_grant(bus_grant),
		.bus_done(bus_done),
		.if_busy(if_busy)
	);

	cycle_report report_i (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.ldstate(ldstate),
		.head(head),
		.stepped(stepped),
		.state(state),
		.rec_valid(rec_valid),
		.rec(rec),
		.cycle_count(cycle_count)
	);

endmodule

/* src/cycle_report.sv */
// Completion record register and wrapping cycle counter
`timescale 1ns/1ps

module cycle_report (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         ldstate,
	input  cpu_timing_pkg::cycle_req_t   head,
	input  logic                         stepped,
	input  cpu_timing_pkg::strob_state_t state,
	output logic                         rec_valid,
	output cpu_timing_pkg::cycle_rec_t   rec,
	output logic [15:0]                  cycle_count
);
	import cpu_timing_pkg::*;

	// Record payload taken from the head still present at ldstate
	always_ff @(posedge clk_sys) begin
		if (ldstate) begin
			rec.tag <= head.tag;
			rec.cls <= head.cls;
			rec.had_strob2 <= has_strob2(head.cls);
			rec.stepped <= stepped;
			rec.mem <= head.mem;
		end
	end

	// Valid strobe one cycle after ldstate
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rec_valid <= 1'b0;
			cycle_count <= '0;
		end else begin
			rec_valid <= ldstate;
			if (ldstate) begin
				// wraps at 16 bits
				cycle_count <= cycle_count + 16'd1;
			end
		end
	end

	// Memory cycles wait out their transfer in s_pgot
	a_mem_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ldstate && head.mem) |-> state == s_pgot)
		else $error("cycle_report: memory cycle ended before its transfer");

endmodule

/* src/bus_track.sv */
// Bus transfer tracker, open and done-seen flags, interface busy output
`timescale 1ns/1ps

module bus_track (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic st1b_pulse,
	input  logic mem,
	input  logic bus_grant,
	input  logic bus_done,
	output logic if_busy
);

	logic xfer_open;
	logic done_seen;
	logic finish;

	// Transfer closes once done has been seen and grant is present
	assign finish = xfer_open && done_seen && bus_grant;

	// Busy from STROB1 back until the cycle after the close
	assign if_busy = xfer_open;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			xfer_open <= 1'b0;
			done_seen <= 1'b0;
		end else begin
			// Open on STROB1 back of a memory cycle
			if (st1b_pulse && mem) begin
				xfer_open <= 1'b1;
			end else if (finish) begin
				xfer_open <= 1'b0;
			end
			// done may arrive while grant is low, keep it until then
			if (finish) begin
				done_seen <= 1'b0;
			end else if (bus_done && xfer_open) begin
				done_seen <= 1'b1;
			end
		end
	end

	// Bus answers only an open transfer
	a_done_when_open: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bus_done |-> xfer_open && !done_seen)
		else $error("bus_track: bus_done without an open transfer");

	// Strobe generator never starts a second transfer before the first closes
	a_no_overlap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(st1b_pulse && mem) |-> !xfer_open)
		else $error("bus_track: transfer opened while busy");

endmodule

/* src/strob_gen.sv */
// Strobe generator FSM with step arming, front panel strobe merge and ldstate
`timescale 1ns/1ps

module strob_gen (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         head_valid,
	input  cpu_timing_pkg::cycle_req_t   head,
	input  logic                         cond_ok,
	input  logic                         if_busy,
	input  logic                         mode,
	input  logic                         step,
	input  logic                         strob_fp,
	input  logic                         strob_fp_b,
	output cpu_timing_pkg::strob_bus_t   strobes,
	output logic                         ldstate,
	output logic                         st1b_pulse,
	output cpu_timing_pkg::strob_state_t state,
	output logic                         stepped
);
	import cpu_timing_pkg::*;

	strob_state_t next_state;
	logic         lstep;
	logic         step_trig;
	logic         es1;
	logic         strob2_cls;
	logic         opening;
	logic         busy;

	// Class decode of the queue head
	assign strob2_cls = has_strob2(head.cls);
	assign es1 = head_valid &&
		((head.cls inside {cls_11, cls_14, cls_15}) ||
		(needs_cond(head.cls) && cond_ok));

	// A memory cycle at STROB1 back is opening its transfer right now
	// if_busy only follows one edge later, so count it as busy here
	assign opening = (state == s_st1b) && head.mem;
	assign busy = if_busy || opening;

	// Step enable, always on with mode low
	assign step_trig = !mode || (step && !lstep);

	// Strobes, STROB1 held high while waiting for step
	assign strobes.got = (state == s_got);
	assign strobes.strob1 = (state == s_st1) || (state == s_st1w) || strob_fp;
	assign strobes.strob1b = (state == s_st1b) || strob_fp_b;
	assign strobes.strob2 = (state == s_st2);
	assign strobes.strob2b = (state == s_st2b);

	assign st1b_pulse = (state == s_st1b);

	// End of cycle, pops the head and latches the record
	assign ldstate = !busy && ((state == s_pgot) ||
		((state == s_st1b) && !strob2_cls) ||
		(state == s_st2b));

	// Next state
	always_comb begin
		next_state = state;
		case (state)
			// Wait for an enabled request
			s_got, s_gotw: begin
				if (es1) begin
					next_state = s_st1;
				end else begin
					next_state = s_gotw;
				end
			end
			// STROB1 front
			s_st1, s_st1w: begin
				if (step_trig) begin
					next_state = s_st1b;
				end else begin
					next_state = s_st1w;
				end
			end
			// STROB1 back
			s_st1b: begin
				if (strob2_cls) begin
					next_state = s_st2;
				end else if (busy) begin
					next_state = s_pgot;
				end else begin
					next_state = s_got;
				end
			end
			// STROB2 front
			s_st2: begin
				next_state = s_st2b;
			end
			// STROB2 back and wait for the bus interface
			s_st2b, s_pgot: begin
				if (busy) begin
					next_state = s_pgot;
				end else begin
					next_state = s_got;
				end
			end
			default: next_state = s_got;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_got;
			lstep <= 1'b0;
			stepped <= 1'b0;
		end else begin
			state <= next_state;
			// Previous step level for edge detect
			lstep <= step;
			// Marks a cycle that held STROB1 for a step
			if (ldstate) begin
				stepped <= 1'b0;
			end else if (state == s_st1w) begin
				stepped <= 1'b1;
			end
		end
	end

	// STROB2 phases only under a STROB2 class head, which the queue holds stable
	a_strob2_class: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(state inside {s_st2, s_st2b}) |-> head_valid && has_strob2(head.cls))
		else $error("strob_gen: STROB2 for a class without STROB2");

endmodule

/* src/cycle_queue.sv */
// Request FIFO with fill counter, sticky overflow flag and head output
`timescale 1ns/1ps

module cycle_queue #(
	parameter int depth = 4
) (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       req_valid,
	input  cpu_timing_pkg::cycle_req_t req,
	input  logic                       pop,
	output logic                       head_valid,
	output cpu_timing_pkg::cycle_req_t head,
	output logic                       overflow
);
	import cpu_timing_pkg::*;

	// Pointer and fill counter widths
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	cycle_req_t     slots [depth];
	logic [aw-1:0]  wr_ptr;
	logic [aw-1:0]  rd_ptr;
	logic [cw-1:0]  fill;
	logic           full;
	logic           push;
	logic           take;

	// Circular pointer advance, depth need not be a power of two
	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
		if (ptr == aw'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (fill == cw'(depth));
	assign head_valid = (fill != '0);

	// Push while full is dropped, even with a pop in the same cycle
	assign push = req_valid && !full;
	assign take = pop && head_valid;

	// Head read straight from storage, stable until popped
	assign head = slots[rd_ptr];

	// Payload storage
	always_ff @(posedge clk_sys) begin
		if (push) begin
			slots[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (take) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Fill only moves when push and pop differ
			case ({push, take})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// Sticky until reset
			if (req_valid && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// Strobe generator ends a cycle only on a queued request
	a_pop_not_empty: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pop |-> head_valid)
		else $error("cycle_queue: pop while empty");

endmodule

/* src/cpu_timing_pkg.sv */
// Cycle class, request and record structs, strobe state encoding, class helpers
package cpu_timing_pkg;

	// Decoded cycle class, one value per ss line of the front end
	typedef enum logic [2:0] {
		cls_11 = 3'd0,
		cls_12 = 3'd1,
		cls_13 = 3'd2,
		cls_14 = 3'd3,
		cls_15 = 3'd4
	} cycle_class_t;

	// One machine cycle request, 12 bits
	typedef struct packed {
		cycle_class_t cls;
		// Transfer opens at STROB1 back
		logic         mem;
		logic [7:0]   tag;
	} cycle_req_t;

	// Completion record, 14 bits
	typedef struct packed {
		logic [7:0]   tag;
		cycle_class_t cls;
		logic         had_strob2;
		// Cycle sat in STROB1 waiting for step
		logic         stepped;
		logic         mem;
	} cycle_rec_t;

	// Strobe generator states
	typedef enum logic [2:0] {
		s_got  = 3'd0,
		s_gotw = 3'd1,
		s_st1  = 3'd2,
		s_st1w = 3'd3,
		s_st1b = 3'd4,
		s_pgot = 3'd5,
		s_st2  = 3'd6,
		s_st2b = 3'd7
	} strob_state_t;

	// Strobe outputs
	typedef struct packed {
		logic got;
		logic strob1;
		logic strob1b;
		logic strob2;
		logic strob2b;
	} strob_bus_t;

	// Classes with a STROB2 phase
	function automatic logic has_strob2(input cycle_class_t cls);
		return (cls == cls_11) || (cls == cls_12);
	endfunction

	// Classes gated by cond_ok before STROB1
	function automatic logic needs_cond(input cycle_class_t cls);
		return (cls == cls_12) || (cls == cls_13);
	endfunction

endpackage
